// File: filelist.f
source/ArithPkg.sv
source/PrefixAnd.sv
source/LeadZeroDet.sv
source/LeadZeroEncode.sv
source/NormShift.sv
source/Normalizer.sv
sim/Normalizer_checker.sv
sim/NormalizerTb.sv

// File: sim/NormalizerTb.sv
`timescale 1ns/100ps
`default_nettype none

module NormalizerTb;

	import ArithPkg::*;

	// lfsr start value for all random stimulus
	localparam logic [31:0] Seed = 32'h4f8d_a71c;
	// galois feedback, taps 32 22 2 1
	localparam logic [31:0] LfsrMask = 32'h8020_0003;
	localparam int RandomCount = 200;
	// cycles allowed for the pipeline to drain
	localparam int TimeoutCycles = 50;
	localparam int TableSize = 12;
	localparam int StreamCount = 10;

	// directed operands with their leading-zero counts
	localparam wordT TableOps [TableSize] = '{
		32'h8000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0002,
		32'h0000_0004, 32'h0000_0010, 32'h0000_0100, 32'h0001_0000,
		32'h4000_0000, 32'h0000_8000, 32'h00F0_0F00, 32'h0000_0003
	};
	localparam shiftT TableCounts [TableSize] = '{
		0, 31, 0, 30,
		29, 27, 23, 15,
		1, 16, 8, 30
	};

	// idle cycles after each streamed operand
	localparam int StreamGaps [StreamCount] = '{0, 0, 1, 0, 2, 0, 0, 3, 1, 0};

	logic  clk;
	logic  rstN;
	logic  inValid;
	wordT  operand;
	logic  outValid;
	wordT  mantissa;
	shiftT leadZeros;
	logic  isZero;

	logic [31:0] lfsrState;
	// rising edges since time zero
	int          cycleCount = 0;
	logic        monitorOn;
	int          errorCount = 0;
	int          checkCount = 0;
	int          testErrors = 0;
	int          testCount = 0;
	int          failedTests = 0;

	// expected results in drive order
	wordT  expMantissa [$];
	shiftT expCount [$];
	logic  expZero [$];
	// cycle in which each result must appear
	int    expDue [$];

	// 20 ns clock
	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) cycleCount <= cycleCount + 1;

	Normalizer i_dut (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.operand  (operand),
		.outValid (outValid),
		.mantissa (mantissa),
		.leadZeros(leadZeros),
		.isZero   (isZero)
	);

	// one lfsr step per bit taken, LSB out first
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsrState[0]};
			if (lfsrState[0]) begin
				lfsrState = (lfsrState >> 1) ^ LfsrMask;
			end else begin
				lfsrState = lfsrState >> 1;
			end
		end
		return r;
	endfunction

	// reference count, scan down from the MSB
	function automatic shiftT refLeadZeros(input wordT v);
		int n;
		n = 0;
		while (n < WordWidth && v[WordWidth-1-n] == 1'b0) begin
			n++;
		end
		// zero word reports zero
		if (n == WordWidth) begin
			n = 0;
		end
		return shiftT'(n);
	endfunction

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		checkCount++;
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkShift(input string name, input shiftT expected, input shiftT actual);
		checkCount++;
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	// call on a falling edge, returns on the next one
	task automatic driveOperand(input wordT v, input shiftT cnt);
		inValid = 1'b1;
		operand = v;
		expMantissa.push_back(v << cnt);
		expCount.push_back(cnt);
		expZero.push_back(v == '0);
		// sampled at the next rising edge, registered out on the edge after
		expDue.push_back(cycleCount + 2);
		@(negedge clk);
	endtask

	task automatic driveIdle(input int n);
		repeat (n) begin
			inValid = 1'b0;
			// junk payload, must not reach the outputs
			operand = 32'hdead_beef;
			@(negedge clk);
		end
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		inValid = 1'b0;
		while (expDue.size() != 0 && waited < TimeoutCycles) begin
			@(negedge clk);
			waited++;
		end
		if (expDue.size() != 0) begin
			$display("timeout: %0d results never left the normalizer", expDue.size());
			errorCount++;
			testErrors++;
			expMantissa.delete();
			expCount.delete();
			expZero.delete();
			expDue.delete();
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (testErrors != 0) begin
			failedTests++;
		end
		$display("test %-10s done, %0d errors", name, testErrors);
		testErrors = 0;
	endtask

	// outputs are stable on the falling edge
	always @(negedge clk) begin
		logic due;
		if (monitorOn) begin
			due = expDue.size() != 0 && expDue[0] == cycleCount;
			checkBit("outValid", due, outValid);
			if (due) begin
				if (outValid === 1'b1) begin
					checkWord("mantissa", expMantissa[0], mantissa);
					checkShift("leadZeros", expCount[0], leadZeros);
					checkBit("isZero", expZero[0], isZero);
				end
				void'(expMantissa.pop_front());
				void'(expCount.pop_front());
				void'(expZero.pop_front());
				void'(expDue.pop_front());
			end
		end
	end

	initial begin
		wordT v;
		int   sh;
		rstN = 1'b0;
		inValid = 1'b0;
		operand = '0;
		lfsrState = Seed;
		monitorOn = 1'b0;

		// reset, 5 rising edges with rstN low
		repeat (5) begin
			@(negedge clk);
			checkBit("outValid", 1'b0, outValid);
		end
		rstN = 1'b1;
		// no strobe in, none out
		repeat (4) begin
			@(negedge clk);
			checkBit("outValid", 1'b0, outValid);
		end
		monitorOn = 1'b1;
		driveOperand(32'h0000_1000, 19);
		waitDrain();
		finishTest("reset");

		// directed table, back to back
		for (int i = 0; i < TableSize; i++) begin
			driveOperand(TableOps[i], TableCounts[i]);
		end
		waitDrain();
		finishTest("directed");

		// zero operands alone and mixed with nonzero ones
		driveOperand('0, 0);
		driveIdle(2);
		driveOperand('0, 0);
		driveOperand(32'h0000_0001, 31);
		driveOperand('0, 0);
		driveOperand(32'hFFFF_FFFF, 0);
		driveOperand('0, 0);
		waitDrain();
		finishTest("zero");

		// streaming with gaps
		for (int i = 0; i < StreamCount; i++) begin
			v = takeBits(WordWidth);
			driveOperand(v, refLeadZeros(v));
			driveIdle(StreamGaps[i]);
		end
		waitDrain();
		finishTest("streaming");

		// random words, shifted right to spread the counts
		for (int i = 0; i < RandomCount; i++) begin
			v = takeBits(WordWidth);
			sh = int'(takeBits(ShiftWidth));
			v = v >> sh;
			driveOperand(v, refLeadZeros(v));
		end
		waitDrain();
		finishTest("random");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/Normalizer_checker.sv
`timescale 1ns/100ps
`default_nettype none

module Normalizer_checker (
	input logic            clk,
	input logic            rstN,
	input logic            inValid,
	input logic            outValid,
	input ArithPkg::wordT  mantissa,
	input logic            isZero
);

	import ArithPkg::*;

	// reset clears the output strobe by the next edge
	resetClearsValid: assert property (@(posedge clk) !rstN |=> !outValid)
		else $error("outValid high right after a reset cycle");

	// fixed two-cycle latency
	// gaps in inValid show up unchanged in outValid
	validLatency: assert property (@(posedge clk)
		$past(rstN) && $past(rstN, 2) |-> outValid == $past(inValid, 2))
		else $error("outValid does not follow inValid by two cycles");

	// zero operand gives an empty mantissa
	zeroResult: assert property (@(posedge clk)
		outValid && isZero |-> mantissa == '0)
		else $error("isZero set with a nonzero mantissa");

	// normalized result always has its top bit set
	msbSet: assert property (@(posedge clk)
		outValid && !isZero |-> mantissa[WordWidth-1])
		else $error("valid nonzero result with mantissa MSB clear");

endmodule

// attach to every normalizer instance
bind Normalizer Normalizer_checker i_checker (.*);

`default_nettype wire

// File: source/ArithPkg.sv
`default_nettype none

package ArithPkg;

	// operand and mantissa width
	localparam int WordWidth = 32;

	// width of the leading-zero count, log2 of the word width
	localparam int ShiftWidth = $clog2(WordWidth);

	// prefix tree used by the normalizer
	// 0 serial chain, 1 Brent-Kung, 2 Sklansky
	localparam int PrefixSpeed = 1;

	// operands, one-hot vectors and mantissas
	typedef logic [WordWidth-1:0] wordT;

	// leading-zero counts
	typedef logic [ShiftWidth-1:0] shiftT;

endpackage

`default_nettype wire

// File: source/LeadZeroDet.sv
`timescale 1ns/100ps
`default_nettype none

module LeadZeroDet #(
	// word width
	parameter int width = 8,
	// prefix tree choice, passed to PrefixAnd
	parameter int speed = 1
) (
	// operand
	input  logic [width-1:0] A,
	// one-hot at the leading one, all zero for a zero operand
	output logic [width-1:0] Z
);

	// inverted operand, MSB moved to bit 0
	logic [width-1:0] piRev;
	// prefix result in reversed order
	logic [width-1:0] poRev;
	// poFwd[i] set when A[width-1:i] is all zero
	logic [width-1:0] poFwd;

	// propagate is "bit is zero", scanned from the MSB down
	for (genvar i = 0; i < width; i++) begin : revIn
		assign piRev[i] = ~A[width-1-i];
	end : revIn

	// e.g. A = 000101 gives 111000 after reversing back
	PrefixAnd #(
		.width(width),
		.speed(speed)
	) i_prefixAnd (
		.PI(piRev),
		.PO(poRev)
	);

	for (genvar i = 0; i < width; i++) begin : revOut
		assign poFwd[i] = poRev[width-1-i];
	end : revOut

	// a bit is the leader when it is set and all bits above are clear
	// MSB has nothing above it
	assign Z[width-1] = A[width-1];

	for (genvar i = 0; i < width - 1; i++) begin : pick
		assign Z[i] = A[i] & poFwd[i+1];
	end : pick

endmodule

`default_nettype wire

// File: source/LeadZeroEncode.sv
`timescale 1ns/100ps
`default_nettype none

module LeadZeroEncode #(
	// word width, matches the one-hot port
	parameter int width = ArithPkg::WordWidth
) (
	// one-hot leading-one position
	input  ArithPkg::wordT  oneHot,
	// zeros above the leading one
	output ArithPkg::shiftT leadZeros,
	// no bit set in oneHot
	output logic            isZero
);

	import ArithPkg::*;

	// per count bit, the one-hot bits whose position sets that bit
	logic [width-1:0] bitSel [ShiftWidth];
	// raw encoder output, already zero for an empty vector
	shiftT            rawCount;

	// position i has width-1-i zeros above it
	// count bit b is the OR of all positions where that number has bit b set
	for (genvar b = 0; b < ShiftWidth; b++) begin : countBits
		for (genvar i = 0; i < width; i++) begin : taps
			if ((((width - 1 - i) >> b) % 2) == 1) begin : tap
				assign bitSel[b][i] = oneHot[i];
			end else begin : noTap
				assign bitSel[b][i] = 1'b0;
			end
		end : taps

		// OR tree
		assign rawCount[b] = |bitSel[b];
	end : countBits

	// only place where the zero operand is recognised
	assign isZero = ~|oneHot;

	// zero operand reports a count of zero
	assign leadZeros = isZero ? '0 : rawCount;

endmodule

`default_nettype wire

// File: source/NormShift.sv
`timescale 1ns/100ps
`default_nettype none

module NormShift (
	// word to normalize
	input  ArithPkg::wordT  operand,
	// left shift amount, the leading-zero count
	input  ArithPkg::shiftT shift,
	// shifted word
	output ArithPkg::wordT  mantissa
);

	import ArithPkg::*;

	// stage[0] is the input, stage[ShiftWidth] the result
	wordT stage [ShiftWidth+1];

	assign stage[0] = operand;

	// barrel shifter, one stage per shift bit
	// stage s moves by 2**s, LSB side filled with zeros
	for (genvar s = 0; s < ShiftWidth; s++) begin : stages
		assign stage[s+1] = shift[s] ? (stage[s] << (2 ** s)) : stage[s];
	end : stages

	// with a correct count the MSB ends up set
	assign mantissa = stage[ShiftWidth];

endmodule

`default_nettype wire

// File: source/Normalizer.sv
`timescale 1ns/100ps
`default_nettype none

module Normalizer (
	input  logic            clk,
	// synchronous, active low
	input  logic            rstN,
	// one strobe per operand
	input  logic            inValid,
	input  ArithPkg::wordT  operand,
	// inValid delayed by two cycles
	output logic            outValid,
	// operand shifted so that its MSB is set
	output ArithPkg::wordT  mantissa,
	// zeros above the leading one
	output ArithPkg::shiftT leadZeros,
	// operand was zero
	output logic            isZero
);

	import ArithPkg::*;

	// leading-one detection on the incoming operand
	wordT  detOneHot;

	// stage 1 registers
	logic  s1Valid;
	wordT  s1Operand;
	wordT  s1OneHot;

	// stage 2 combinational results
	shiftT encCount;
	logic  encZero;
	wordT  shifted;

	// stage 1 logic
	// detection runs ahead of the first register
	LeadZeroDet #(
		.width(WordWidth),
		.speed(PrefixSpeed)
	) i_leadZeroDet (
		.A(operand),
		.Z(detOneHot)
	);

	// valid bit is the only control state
	always_ff @(posedge clk) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
		end else begin
			s1Valid <= inValid;
		end
	end

	// payload only loads with a valid operand
	always_ff @(posedge clk) begin
		if (inValid) begin
			s1Operand <= operand;
			s1OneHot  <= detOneHot;
		end
	end

	// stage 2 logic
	// count and zero flag from the registered one-hot
	LeadZeroEncode #(
		.width(WordWidth)
	) i_leadZeroEncode (
		.oneHot   (s1OneHot),
		.leadZeros(encCount),
		.isZero   (encZero)
	);

	// zero operand gives count 0 and so a zero mantissa
	NormShift i_normShift (
		.operand (s1Operand),
		.shift   (encCount),
		.mantissa(shifted)
	);

	// output valid
	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= s1Valid;
		end
	end

	// output data, held between valid results
	always_ff @(posedge clk) begin
		if (s1Valid) begin
			mantissa  <= shifted;
			leadZeros <= encCount;
			isZero    <= encZero;
		end
	end

endmodule

`default_nettype wire

// File: source/PrefixAnd.sv
`timescale 1ns/100ps
`default_nettype none

module PrefixAnd #(
	// word width
	parameter int width = 8,
	// 0 serial, 1 Brent-Kung, 2 Sklansky
	parameter int speed = 1
) (
	// propagate in
	input  logic [width-1:0] PI,
	// running AND from bit 0 upward
	output logic [width-1:0] PO
);

	// PO[j] is the AND of PI[j:0] in every variant
	// the trees differ only in depth and node count

	if (speed == 2) begin : sklansky
		// log2(width) levels, fan-out doubles per level
		logic [width-1:0] pt [0:$clog2(width)];

		assign pt[0] = PI;

		for (genvar l = 1; l <= $clog2(width); l++) begin : levels
			for (genvar j = 0; j < width; j++) begin : bits
				// upper half of each 2**l group takes the top of the lower half
				if (((j >> (l - 1)) % 2) == 1) begin : black
					assign pt[l][j] = pt[l-1][j] & pt[l-1][((j >> (l - 1)) << (l - 1)) - 1];
				end else begin : white
					assign pt[l][j] = pt[l-1][j];
				end
			end : bits
		end : levels

		assign PO = pt[$clog2(width)];
	end : sklansky

	else if (speed == 1) begin : brentKung
		// up-sweep of log2(width) levels, then down-sweep of log2(width)-1
		logic [width-1:0] pt [0:2*$clog2(width)-1];

		assign pt[0] = PI;

		// up-sweep
		// top bit of each aligned 2**l block collects the whole block
		for (genvar l = 1; l <= $clog2(width); l++) begin : upLevels
			for (genvar j = 0; j < width; j++) begin : bits
				if (((j + 1) % (2 ** l)) == 0) begin : black
					assign pt[l][j] = pt[l-1][j] & pt[l-1][j-2**(l-1)];
				end else begin : white
					assign pt[l][j] = pt[l-1][j];
				end
			end : bits
		end : upLevels

		// down-sweep
		// span shrinks from width/4 down to 1
		for (genvar l = $clog2(width) + 1; l <= 2 * $clog2(width) - 1; l++) begin : downLevels
			for (genvar j = 0; j < width; j++) begin : bits
				// mid point of each span block above the first one
				if ((j >= 2 ** (2 * $clog2(width) - l))
						&& ((j % (2 ** (2 * $clog2(width) - l)))
							== (2 ** (2 * $clog2(width) - l - 1) - 1))) begin : black
					// pull in the finished prefix just below this block
					assign pt[l][j] = pt[l-1][j]
						& pt[l-1][(j / 2 ** (2 * $clog2(width) - l))
							* 2 ** (2 * $clog2(width) - l) - 1];
				end else begin : white
					assign pt[l][j] = pt[l-1][j];
				end
			end : bits
		end : downLevels

		assign PO = pt[2*$clog2(width)-1];
	end : brentKung

	else begin : serial
		// ripple chain, smallest and slowest
		// also taken for any unknown speed value
		logic [width-1:0] pt;

		assign pt[0] = PI[0];

		for (genvar j = 1; j < width; j++) begin : bits
			assign pt[j] = pt[j-1] & PI[j];
		end : bits

		assign PO = pt;
	end : serial

endmodule

`default_nettype wire
